// File: ul_compress.f
+incdir+.
ul_compress_pkg.sv
register_shift.sv
prb_max_exp.sv
compress_bit.sv
ul_compress_data.sv
tb_ul_compress_data.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ul_compress_data
FILELIST := ul_compress.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_ul_compress_ref.svh
`ifndef TB_UL_COMPRESS_REF_SVH
`define TB_UL_COMPRESS_REF_SVH

// Negative components count by their bitwise inverse
function automatic logic [15:0] magnitude(input logic [15:0] c);
    if (c[15]) begin
        return ~c;
    end
    return c;
endfunction

// Shift of one PRB: needed width with sign, minus the compressed width
function automatic logic [ul_compress_pkg::SHIFT_W-1:0] prb_shift(
    input logic [ul_compress_pkg::RE_PER_PRB-1:0][31:0] re
);
    logic [15:0] mag_or;
    int          width;
    int          sh;
    mag_or = '0;
    for (int k = 0; k < ul_compress_pkg::RE_PER_PRB; k++) begin
        mag_or = mag_or | magnitude(re[k][15:0]) | magnitude(re[k][31:16]);
    end
    // Search from the top for the first set bit
    width = 1;
    for (int b = 15; b >= 0; b--) begin
        if (mag_or[b] && width == 1) begin
            width = b + 2;
        end
    end
    sh = (width > ul_compress_pkg::COMP_W) ? width - ul_compress_pkg::COMP_W : 0;
    return sh[ul_compress_pkg::SHIFT_W-1:0];
endfunction

// One RE after the shift, Q in the high half
function automatic logic [2*ul_compress_pkg::COMP_W-1:0] compress_re(
    input logic [31:0]                         s,
    input logic [ul_compress_pkg::SHIFT_W-1:0] sh
);
    logic signed [15:0] i_val;
    logic signed [15:0] q_val;
    i_val = s[15:0];
    q_val = s[31:16];
    i_val = i_val >>> sh;
    q_val = q_val >>> sh;
    return {q_val[ul_compress_pkg::COMP_W-1:0], i_val[ul_compress_pkg::COMP_W-1:0]};
endfunction

`endif

// File: tb_ul_compress_data.sv
`timescale 1ns/1ps

module tb_ul_compress_data;

    localparam int COMP_W  = ul_compress_pkg::COMP_W;
    localparam int SHIFT_W = ul_compress_pkg::SHIFT_W;
    localparam int NUM_ANT = ul_compress_pkg::NUM_ANT;
    localparam int RE_N    = ul_compress_pkg::RE_PER_PRB;
    localparam int LATENCY = ul_compress_pkg::LATENCY;
    localparam int NUM_PRB = 48;
    localparam int TIMEOUT = NUM_PRB * 30 + 200;

    `include "tb_ul_compress_ref.svh"

    // One output cycle as the DUT should present it
    typedef struct packed {
        logic [3:0]                       strb;
        logic [NUM_ANT-1:0][2*COMP_W-1:0] data;
        logic [NUM_ANT-1:0][SHIFT_W-1:0]  shift;
        logic [23:0]                      desc;
        logic [NUM_ANT-1:0][3:0]          ch_type;
        logic [NUM_ANT-1:0][7:0]          info;
        logic [3:0][63:0]                 pwr;
    } expect_t;

    logic        clk;
    logic        i_arst_n;
    logic [3:0]  i_sel, i_sop, i_eop, i_vld;
    logic [31:0] i_din_ant0, i_din_ant1, i_din_ant2, i_din_ant3;
    logic [6:0]  i_slot_idx, o_slot_idx;
    logic [3:0]  i_symb_idx, o_symb_idx;
    logic [8:0]  i_prb_idx, o_prb_idx;
    logic [3:0]  i_rbg_idx, o_rbg_idx;
    logic [3:0]  i_channel_type0, i_channel_type1, i_channel_type2, i_channel_type3;
    logic [7:0]  i_info0, i_info1, i_info2, i_info3;
    logic [31:0] i_ant_power0, i_ant_power1, i_ant_power2, i_ant_power3;
    logic [31:0] i_ant_power4, i_ant_power5, i_ant_power6, i_ant_power7;
    logic        o_sel, o_sop, o_eop, o_vld;
    logic [2*COMP_W-1:0] o_data_ant0, o_data_ant1, o_data_ant2, o_data_ant3;
    logic [SHIFT_W-1:0]  o_shift0, o_shift1, o_shift2, o_shift3;
    logic [3:0]  o_channel_type0, o_channel_type1, o_channel_type2, o_channel_type3;
    logic [7:0]  o_info0, o_info1, o_info2, o_info3;
    logic [63:0] o_pkg0_power, o_pkg1_power, o_pkg2_power, o_pkg3_power;

    logic [NUM_ANT-1:0][2*COMP_W-1:0]  got_data;
    logic [NUM_ANT-1:0][SHIFT_W-1:0]   got_shift;
    logic [NUM_ANT-1:0][3:0]           got_type;
    logic [NUM_ANT-1:0][7:0]           got_info;
    logic [3:0][63:0]                  got_pwr;
    logic [NUM_ANT-1:0][RE_N-1:0][31:0] prb_data;
    logic [NUM_ANT-1:0][SHIFT_W-1:0]   prb_sh;
    expect_t                           exp_q[$];
    logic                              drive_started;
    logic                              stim_done;

    ul_compress_data #(.COMP_W(COMP_W)) i_dut (.*);

    assign got_data  = {o_data_ant3, o_data_ant2, o_data_ant1, o_data_ant0};
    assign got_shift = {o_shift3, o_shift2, o_shift1, o_shift0};
    assign got_type  = {o_channel_type3, o_channel_type2, o_channel_type1, o_channel_type0};
    assign got_info  = {o_info3, o_info2, o_info1, o_info0};
    assign got_pwr   = {o_pkg3_power, o_pkg2_power, o_pkg1_power, o_pkg0_power};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val);
        assert (got_val === exp_val) else begin
            stop_on_failure($sformatf("mismatch %s exp=%0h got=%0h", name, exp_val, got_val));
        end
    endtask

    // Signed random component limited to a bit width
    function automatic logic [15:0] rand_component(input int width);
        logic [15:0] v;
        v = 16'($urandom);
        for (int b = width; b < 16; b++) begin
            v[b] = v[width-1];
        end
        return v;
    endfunction

    task automatic make_prb();
        int width;
        int pos;
        for (int a = 0; a < NUM_ANT; a++) begin
            width = $urandom_range(1, 16);
            pos   = $urandom_range(0, RE_N - 1);
            for (int r = 0; r < RE_N; r++) begin
                prb_data[a][r] = {rand_component(width), rand_component(width)};
            end
            // Now and then a full-scale extreme
            case ($urandom_range(0, 7))
                0: prb_data[a][pos][15:0] = 16'h8000;
                1: prb_data[a][pos][31:16] = 16'h7fff;
                default: ;
            endcase
            prb_sh[a] = prb_shift(prb_data[a]);
        end
    endtask

    task automatic drive_cycle(input logic vld, input logic sop, input logic eop, input int re);
        expect_t              e;
        logic [3:0]           sel;
        logic [3:0][31:0]     din;
        logic [23:0]          desc;
        logic [3:0][3:0]      ch_type;
        logic [3:0][7:0]      info;
        logic [7:0][31:0]     pwr;
        sel     = 4'($urandom);
        desc    = 24'($urandom);
        ch_type = 16'($urandom);
        info    = $urandom;
        for (int p = 0; p < 8; p++) begin
            pwr[p] = $urandom;
        end
        for (int a = 0; a < NUM_ANT; a++) begin
            din[a] = vld ? prb_data[a][re] : $urandom;
        end
        @(posedge clk);
        i_sel <= sel;
        i_sop <= {4{sop}};
        i_eop <= {4{eop}};
        i_vld <= {4{vld}};
        {i_din_ant3, i_din_ant2, i_din_ant1, i_din_ant0} <= din;
        {i_slot_idx, i_symb_idx, i_prb_idx, i_rbg_idx} <= desc;
        {i_channel_type3, i_channel_type2, i_channel_type1, i_channel_type0} <= ch_type;
        {i_info3, i_info2, i_info1, i_info0} <= info;
        {i_ant_power7, i_ant_power6, i_ant_power5, i_ant_power4,
         i_ant_power3, i_ant_power2, i_ant_power1, i_ant_power0} <= pwr;
        e.strb = {sel[0], sop, eop, vld};
        for (int a = 0; a < NUM_ANT; a++) begin
            e.data[a]  = compress_re(din[a], prb_sh[a]);
            e.shift[a] = prb_sh[a];
        end
        // Odd power word in the high half
        for (int k = 0; k < 4; k++) begin
            e.pwr[k] = {pwr[2*k+1], pwr[2*k]};
        end
        e.desc    = desc;
        e.ch_type = ch_type;
        e.info    = info;
        exp_q.push_back(e);
        drive_started = 1'b1;
    endtask

    task automatic compare_outputs(input expect_t e);
        check_field("o_sel", e.strb[3], o_sel);
        check_field("o_sop", e.strb[2], o_sop);
        check_field("o_eop", e.strb[1], o_eop);
        check_field("o_vld", e.strb[0], o_vld);
        check_field("o_slot_idx", e.desc[23:17], o_slot_idx);
        check_field("o_symb_idx", e.desc[16:13], o_symb_idx);
        check_field("o_prb_idx", e.desc[12:4], o_prb_idx);
        check_field("o_rbg_idx", e.desc[3:0], o_rbg_idx);
        for (int a = 0; a < NUM_ANT; a++) begin
            check_field($sformatf("o_channel_type%0d", a), e.ch_type[a], got_type[a]);
            check_field($sformatf("o_info%0d", a), e.info[a], got_info[a]);
            check_field($sformatf("o_pkg%0d_power", a), e.pwr[a], got_pwr[a]);
            if (e.strb[0]) begin
                check_field($sformatf("o_shift%0d", a), e.shift[a], got_shift[a]);
                check_field($sformatf("o_data_ant%0d", a), e.data[a], got_data[a]);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        int gap;
        drive_started = 1'b0;
        stim_done     = 1'b0;
        void'($urandom(32'h6229410d));
        i_arst_n <= 1'b0;
        {i_sel, i_sop, i_eop, i_vld} <= '0;
        {i_din_ant0, i_din_ant1, i_din_ant2, i_din_ant3} <= '0;
        {i_slot_idx, i_symb_idx, i_prb_idx, i_rbg_idx} <= '0;
        {i_channel_type0, i_channel_type1, i_channel_type2, i_channel_type3} <= '0;
        {i_info0, i_info1, i_info2, i_info3} <= '0;
        {i_ant_power0, i_ant_power1, i_ant_power2, i_ant_power3} <= '0;
        {i_ant_power4, i_ant_power5, i_ant_power6, i_ant_power7} <= '0;
        repeat (2) @(posedge clk);
        i_arst_n <= 1'b1;
        for (int n = 0; n < NUM_PRB; n++) begin
            make_prb();
            for (int r = 0; r < RE_N; r++) begin
                drive_cycle(1'b1, r == 0, r == RE_N - 1, r);
            end
            // First half back to back, then random gaps
            gap = (n < NUM_PRB / 2) ? 0 : $urandom_range(0, 6);
            repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, 0);
        end
        stim_done = 1'b1;
    end

    // ------------------------------------------------------------
    // Compare at the falling edge
    // ------------------------------------------------------------
    initial begin : compare
        int lag;
        lag = 0;
        forever begin
            @(negedge clk);
            if (drive_started) begin
                lag++;
            end
            if (lag <= LATENCY) begin
                // Pipeline still holds reset values
                check_field("o_sel", 64'd0, o_sel);
                check_field("o_sop", 64'd0, o_sop);
                check_field("o_eop", 64'd0, o_eop);
                check_field("o_vld", 64'd0, o_vld);
            end else if (exp_q.size() > 0) begin
                compare_outputs(exp_q.pop_front());
            end else if (stim_done) begin
                break;
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                stop_on_failure("timeout, the run did not finish within the cycle limit");
            end
        end
    end

endmodule

// File: ul_compress_data.sv
`timescale 1ns/1ps

module ul_compress_data #(
    parameter int COMP_W = ul_compress_pkg::COMP_W
) (
    input  logic                                  clk,
    input  logic                                  i_arst_n,
    input  logic [3:0]                            i_sel,
    input  logic [3:0]                            i_sop,
    input  logic [3:0]                            i_eop,
    input  logic [3:0]                            i_vld,
    input  logic [31:0]                           i_din_ant0,
    input  logic [31:0]                           i_din_ant1,
    input  logic [31:0]                           i_din_ant2,
    input  logic [31:0]                           i_din_ant3,
    input  logic [ul_compress_pkg::SLOT_W-1:0]    i_slot_idx,
    input  logic [ul_compress_pkg::SYMB_W-1:0]    i_symb_idx,
    input  logic [ul_compress_pkg::PRB_W-1:0]     i_prb_idx,
    input  logic [ul_compress_pkg::RBG_W-1:0]     i_rbg_idx,
    input  logic [ul_compress_pkg::CHTYPE_W-1:0]  i_channel_type0,
    input  logic [ul_compress_pkg::CHTYPE_W-1:0]  i_channel_type1,
    input  logic [ul_compress_pkg::CHTYPE_W-1:0]  i_channel_type2,
    input  logic [ul_compress_pkg::CHTYPE_W-1:0]  i_channel_type3,
    input  logic [ul_compress_pkg::INFO_W-1:0]    i_info0,
    input  logic [ul_compress_pkg::INFO_W-1:0]    i_info1,
    input  logic [ul_compress_pkg::INFO_W-1:0]    i_info2,
    input  logic [ul_compress_pkg::INFO_W-1:0]    i_info3,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power0,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power1,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power2,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power3,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power4,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power5,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power6,
    input  logic [ul_compress_pkg::PWR_W-1:0]     i_ant_power7,
    output logic                                  o_sel,
    output logic                                  o_sop,
    output logic                                  o_eop,
    output logic                                  o_vld,
    output logic [2*COMP_W-1:0]                   o_data_ant0,
    output logic [2*COMP_W-1:0]                   o_data_ant1,
    output logic [2*COMP_W-1:0]                   o_data_ant2,
    output logic [2*COMP_W-1:0]                   o_data_ant3,
    output logic [ul_compress_pkg::SHIFT_W-1:0]   o_shift0,
    output logic [ul_compress_pkg::SHIFT_W-1:0]   o_shift1,
    output logic [ul_compress_pkg::SHIFT_W-1:0]   o_shift2,
    output logic [ul_compress_pkg::SHIFT_W-1:0]   o_shift3,
    output logic [ul_compress_pkg::SLOT_W-1:0]    o_slot_idx,
    output logic [ul_compress_pkg::SYMB_W-1:0]    o_symb_idx,
    output logic [ul_compress_pkg::PRB_W-1:0]     o_prb_idx,
    output logic [ul_compress_pkg::RBG_W-1:0]     o_rbg_idx,
    output logic [ul_compress_pkg::CHTYPE_W-1:0]  o_channel_type0,
    output logic [ul_compress_pkg::CHTYPE_W-1:0]  o_channel_type1,
    output logic [ul_compress_pkg::CHTYPE_W-1:0]  o_channel_type2,
    output logic [ul_compress_pkg::CHTYPE_W-1:0]  o_channel_type3,
    output logic [ul_compress_pkg::INFO_W-1:0]    o_info0,
    output logic [ul_compress_pkg::INFO_W-1:0]    o_info1,
    output logic [ul_compress_pkg::INFO_W-1:0]    o_info2,
    output logic [ul_compress_pkg::INFO_W-1:0]    o_info3,
    output logic [63:0]                           o_pkg0_power,
    output logic [63:0]                           o_pkg1_power,
    output logic [63:0]                           o_pkg2_power,
    output logic [63:0]                           o_pkg3_power
);

    localparam int NUM_ANT  = ul_compress_pkg::NUM_ANT;
    localparam int NUM_PWR  = ul_compress_pkg::NUM_PWR;
    localparam int PWR_W    = ul_compress_pkg::PWR_W;
    localparam int SHIFT_W  = ul_compress_pkg::SHIFT_W;
    localparam int CHTYPE_W = ul_compress_pkg::CHTYPE_W;
    localparam int INFO_W   = ul_compress_pkg::INFO_W;
    localparam int LATENCY  = ul_compress_pkg::LATENCY;
    localparam int DESC_W   = ul_compress_pkg::SLOT_W + ul_compress_pkg::SYMB_W
                            + ul_compress_pkg::PRB_W + ul_compress_pkg::RBG_W;

    logic [NUM_ANT-1:0][31:0]          ant_din;
    logic [NUM_ANT-1:0][CHTYPE_W-1:0]  ant_type_in;
    logic [NUM_ANT-1:0][INFO_W-1:0]    ant_info_in;
    logic [NUM_ANT-1:0][2*COMP_W-1:0]  ant_dout;
    logic [NUM_ANT-1:0][SHIFT_W-1:0]   ant_shift;
    logic [NUM_ANT-1:0][CHTYPE_W-1:0]  ant_type_out;
    logic [NUM_ANT-1:0][INFO_W-1:0]    ant_info_out;
    logic [NUM_ANT-1:0]                ant_sel;
    logic [NUM_ANT-1:0]                ant_sop;
    logic [NUM_ANT-1:0]                ant_eop;
    logic [NUM_ANT-1:0]                ant_vld;
    logic [NUM_PWR-1:0][PWR_W-1:0]     pwr;
    logic [NUM_PWR-1:0][PWR_W-1:0]     pwr_d;

    // ------------------------------------------------------------
    // Per-antenna compression
    // ------------------------------------------------------------
    assign ant_din     = {i_din_ant3, i_din_ant2, i_din_ant1, i_din_ant0};
    assign ant_type_in = {i_channel_type3, i_channel_type2, i_channel_type1, i_channel_type0};
    assign ant_info_in = {i_info3, i_info2, i_info1, i_info0};

    for (genvar a = 0; a < NUM_ANT; a++) begin : gen_ant
        compress_bit #(
            .COMP_W     (COMP_W)
        ) u_compress_bit (
            .clk        (clk),
            .i_arst_n   (i_arst_n),
            .i_sel      (i_sel[a]),
            .i_sop      (i_sop[a]),
            .i_eop      (i_eop[a]),
            .i_vld      (i_vld[a]),
            .i_din      (ant_din[a]),
            .i_ch_type  (ant_type_in[a]),
            .i_info     (ant_info_in[a]),
            .o_sel      (ant_sel[a]),
            .o_sop      (ant_sop[a]),
            .o_eop      (ant_eop[a]),
            .o_vld      (ant_vld[a]),
            .o_dout     (ant_dout[a]),
            .o_shift    (ant_shift[a]),
            .o_type     (ant_type_out[a]),
            .o_info     (ant_info_out[a])
        );
    end

    // Antennas are time aligned, antenna 0 stands for all
    assign o_sel = ant_sel[0];
    assign o_sop = ant_sop[0];
    assign o_eop = ant_eop[0];
    assign o_vld = ant_vld[0];

    assign {o_data_ant3, o_data_ant2, o_data_ant1, o_data_ant0} = ant_dout;
    assign {o_shift3, o_shift2, o_shift1, o_shift0}             = ant_shift;
    assign {o_channel_type3, o_channel_type2,
            o_channel_type1, o_channel_type0}                   = ant_type_out;
    assign {o_info3, o_info2, o_info1, o_info0}                 = ant_info_out;

    // ------------------------------------------------------------
    // Shared descriptors
    // ------------------------------------------------------------
    register_shift #(
        .T          (logic [DESC_W-1:0]),
        .DEPTH      (LATENCY)
    ) u_dly_desc (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_din      ({i_slot_idx, i_symb_idx, i_prb_idx, i_rbg_idx}),
        .o_dout     ({o_slot_idx, o_symb_idx, o_prb_idx, o_rbg_idx})
    );

    // ------------------------------------------------------------
    // Antenna power delay and packing
    // ------------------------------------------------------------
    assign pwr = {i_ant_power7, i_ant_power6, i_ant_power5, i_ant_power4,
                  i_ant_power3, i_ant_power2, i_ant_power1, i_ant_power0};

    for (genvar p = 0; p < NUM_PWR; p++) begin : gen_pwr
        register_shift #(
            .T          (logic [PWR_W-1:0]),
            .DEPTH      (LATENCY)
        ) u_dly_pwr (
            .clk        (clk),
            .i_arst_n   (i_arst_n),
            .i_din      (pwr[p]),
            .o_dout     (pwr_d[p])
        );
    end

    // Word 2k+1 lands in the high half of package k
    assign {o_pkg3_power, o_pkg2_power, o_pkg1_power, o_pkg0_power} = pwr_d;

endmodule

// File: compress_bit.sv
`timescale 1ns/1ps

module compress_bit #(
    parameter int COMP_W = ul_compress_pkg::COMP_W
) (
    input  logic                                  clk,
    input  logic                                  i_arst_n,
    input  logic                                  i_sel,
    input  logic                                  i_sop,
    input  logic                                  i_eop,
    input  logic                                  i_vld,
    input  logic [31:0]                           i_din,
    input  logic [ul_compress_pkg::CHTYPE_W-1:0]  i_ch_type,
    input  logic [ul_compress_pkg::INFO_W-1:0]    i_info,
    output logic                                  o_sel,
    output logic                                  o_sop,
    output logic                                  o_eop,
    output logic                                  o_vld,
    output logic [2*COMP_W-1:0]                   o_dout,
    output logic [ul_compress_pkg::SHIFT_W-1:0]   o_shift,
    output logic [ul_compress_pkg::CHTYPE_W-1:0]  o_type,
    output logic [ul_compress_pkg::INFO_W-1:0]    o_info
);

    localparam int IQ_W     = ul_compress_pkg::IQ_W;
    localparam int SHIFT_W  = ul_compress_pkg::SHIFT_W;
    localparam int LATENCY  = ul_compress_pkg::LATENCY;
    localparam int CHTYPE_W = ul_compress_pkg::CHTYPE_W;
    localparam int TI_W     = CHTYPE_W + ul_compress_pkg::INFO_W;

    logic                     exp_vld;
    logic [SHIFT_W-1:0]       exp_val;
    logic [3:0]               strb_d;
    logic [31:0]              din_d;
    logic [TI_W-1:0]          ti_d;
    logic [SHIFT_W-1:0]       q_head;
    logic [SHIFT_W-1:0]       q_tail;
    logic [1:0]               q_cnt;
    logic                     q_push;
    logic                     q_pop;
    logic signed [IQ_W-1:0]   samp_i;
    logic signed [IQ_W-1:0]   samp_q;
    logic signed [IQ_W-1:0]   shr_i;
    logic signed [IQ_W-1:0]   shr_q;

    prb_max_exp #(
        .COMP_W     (COMP_W)
    ) u_prb_max_exp (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_vld      (i_vld),
        .i_sop      (i_sop),
        .i_eop      (i_eop),
        .i_din      (i_din),
        .o_exp_vld  (exp_vld),
        .o_exp      (exp_val)
    );

    // ------------------------------------------------------------
    // Delay lines
    // ------------------------------------------------------------

    // Strobes and samples stop one short, the output register adds the last
    register_shift #(
        .T          (logic [3:0]),
        .DEPTH      (LATENCY - 1)
    ) u_dly_strb (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_din      ({i_sel, i_sop, i_eop, i_vld}),
        .o_dout     (strb_d)
    );

    register_shift #(
        .T          (logic [31:0]),
        .DEPTH      (LATENCY - 1)
    ) u_dly_din (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_din      (i_din),
        .o_dout     (din_d)
    );

    register_shift #(
        .T          (logic [TI_W-1:0]),
        .DEPTH      (LATENCY)
    ) u_dly_type_info (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_din      ({i_ch_type, i_info}),
        .o_dout     (ti_d)
    );

    assign o_type = ti_d[TI_W-1 -: CHTYPE_W];
    assign o_info = ti_d[TI_W-CHTYPE_W-1:0];

    // ------------------------------------------------------------
    // Exponent queue, two PRBs in flight at most
    // ------------------------------------------------------------
    assign q_push = exp_vld;
    assign q_pop  = strb_d[1] & strb_d[0];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q_cnt <= '0;
        end else begin
            q_cnt <= q_cnt + 2'(q_push) - 2'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            // With one entry left the new exponent goes straight to the head
            if (q_cnt == 2'd2) begin
                q_head <= q_tail;
            end else begin
                q_head <= exp_val;
            end
            if (q_push) begin
                q_tail <= exp_val;
            end
        end else if (q_push) begin
            if (q_cnt == 2'd0) begin
                q_head <= exp_val;
            end else begin
                q_tail <= exp_val;
            end
        end
    end

    // ------------------------------------------------------------
    // Shift, truncate and register
    // ------------------------------------------------------------
    assign samp_i = din_d[IQ_W-1:0];
    assign samp_q = din_d[2*IQ_W-1:IQ_W];
    assign shr_i  = samp_i >>> q_head;
    assign shr_q  = samp_q >>> q_head;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {o_sel, o_sop, o_eop, o_vld} <= '0;
        end else begin
            {o_sel, o_sop, o_eop, o_vld} <= strb_d;
        end
    end

    always_ff @(posedge clk) begin
        o_dout  <= {shr_q[COMP_W-1:0], shr_i[COMP_W-1:0]};
        o_shift <= q_head;
    end

endmodule

// File: prb_max_exp.sv
`timescale 1ns/1ps

module prb_max_exp #(
    parameter int COMP_W = ul_compress_pkg::COMP_W
) (
    input  logic                                 clk,
    input  logic                                 i_arst_n,
    input  logic                                 i_vld,
    input  logic                                 i_sop,
    input  logic                                 i_eop,
    input  logic [31:0]                          i_din,
    output logic                                 o_exp_vld,
    output logic [ul_compress_pkg::SHIFT_W-1:0]  o_exp
);

    localparam int IQ_W    = ul_compress_pkg::IQ_W;
    localparam int SHIFT_W = ul_compress_pkg::SHIFT_W;

    logic [IQ_W-1:0]    mag_i;
    logic [IQ_W-1:0]    mag_q;
    logic [IQ_W-1:0]    mag_re;
    logic [IQ_W-1:0]    acc;
    logic [IQ_W-1:0]    acc_next;
    logic [4:0]         sig_bits;
    logic [4:0]         need_bits;
    logic [SHIFT_W-1:0] shift_next;

    // ------------------------------------------------------------
    // Magnitude OR over the PRB
    // ------------------------------------------------------------

    // Negative values are inverted, so -1 counts like 0
    assign mag_i  = i_din[IQ_W-1]   ? ~i_din[IQ_W-1:0]    : i_din[IQ_W-1:0];
    assign mag_q  = i_din[2*IQ_W-1] ? ~i_din[2*IQ_W-1:IQ_W] : i_din[2*IQ_W-1:IQ_W];
    assign mag_re = mag_i | mag_q;

    // Restart on the first RE of a PRB
    assign acc_next = i_sop ? mag_re : (acc | mag_re);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            acc <= '0;
        end else if (i_vld) begin
            acc <= acc_next;
        end
    end

    // ------------------------------------------------------------
    // Leading one and shift
    // ------------------------------------------------------------
    always_comb begin
        sig_bits = '0;
        for (int b = 0; b < IQ_W; b++) begin
            if (acc_next[b]) begin
                sig_bits = 5'(b + 1);
            end
        end
    end

    // One extra bit for the sign
    assign need_bits  = sig_bits + 5'd1;
    assign shift_next = (need_bits > 5'(COMP_W)) ? SHIFT_W'(need_bits - 5'(COMP_W)) : '0;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_exp_vld <= 1'b0;
        end else begin
            o_exp_vld <= i_vld & i_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld && i_eop) begin
            o_exp <= shift_next;
        end
    end

endmodule

// File: register_shift.sv
`timescale 1ns/1ps

module register_shift #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic i_arst_n,
    input  T     i_din,
    output T     o_dout
);

    // Stage 0 takes the input, the last stage drives the output
    T stage [DEPTH];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= i_din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign o_dout = stage[DEPTH-1];

endmodule

// File: ul_compress_pkg.sv
package ul_compress_pkg;

    // ------------------------------------------------------------
    // IQ sample format
    // ------------------------------------------------------------

    // One I or Q component of the incoming 32-bit sample
    localparam int IQ_W       = 16;

    // Compressed component width, top level default
    localparam int COMP_W     = 7;

    // PRB exponent, range 0 to 9 for the default COMP_W
    localparam int SHIFT_W    = 4;

    // Resource elements in one PRB
    localparam int RE_PER_PRB = 12;

    // Input to output delay of the whole stage
    localparam int LATENCY    = 19;

    // ------------------------------------------------------------
    // Descriptor fields
    // ------------------------------------------------------------
    localparam int SLOT_W     = 7;
    localparam int SYMB_W     = 4;
    localparam int PRB_W      = 9;
    localparam int RBG_W      = 4;
    localparam int CHTYPE_W   = 4;
    localparam int INFO_W     = 8;

    // ------------------------------------------------------------
    // Antennas and power words
    // ------------------------------------------------------------
    localparam int NUM_ANT    = 4;

    // Eight power words leave as four 64-bit pairs
    localparam int NUM_PWR    = 8;
    localparam int PWR_W      = 32;

endpackage
